/* verilog/rv_pkg.sv */
package rv_pkg;

    // ---------------------------------------------------------------------
    // widths and fixed addresses
    // ---------------------------------------------------------------------

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [XLEN-1:0] RESET_PC   = 32'h0000_0000; // first fetch after reset
    localparam logic [XLEN-1:0] INSTR_STEP = 32'd4;         // sequential pc increment

    // ---------------------------------------------------------------------
    // major opcodes, instruction bits 6:2
    // ---------------------------------------------------------------------

    // anything not listed here runs as a no-op
    typedef enum logic [4:0] {
        OP_IMM = 5'b00100,
        AUIPC  = 5'b00101,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        BRANCH = 5'b11000,
        JALR   = 5'b11001,
        JAL    = 5'b11011
    } mopcode_e;

    // ---------------------------------------------------------------------
    // alu operations, encoded as {funct7[5], funct3}
    // ---------------------------------------------------------------------

    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        OR   = 4'b0110,
        AND  = 4'b0111,
        SUB  = 4'b1000,
        SRA  = 4'b1101
    } alu_op_e;

    // branch conditions, same codes as the funct3 field
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_cond_e;

    // core sequencer
    typedef enum logic [1:0] {
        FETCH       = 2'b00, // request issued
        ACK_WAIT    = 2'b01, // req held until ack
        ACK_RELEASE = 2'b10, // req low, wait for ack to drop
        EXECUTE     = 2'b11  // one cycle, write back and pc update
    } core_state_e;

endpackage

/* verilog/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic                          rd_we_i,
    input  logic [rv_pkg::XLEN-1:0]       rd_data_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o
);

    // x1..x31 only, x0 has no storage
    logic [rv_pkg::XLEN-1:0] regs [1:rv_pkg::NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we_i && (rd_addr_i != '0)) begin
            regs[rd_addr_i] <= rd_data_i; // writes to x0 dropped
        end
    end

    // combinational read ports
    always_comb begin
        rs1_data_o = '0;
        rs2_data_o = '0;
        if (rs1_addr_i != '0) begin
            rs1_data_o = regs[rs1_addr_i];
        end
        if (rs2_addr_i != '0) begin
            rs2_data_o = regs[rs2_addr_i];
        end
    end

endmodule

/* verilog/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
    input  logic [rv_pkg::XLEN-1:0] op_a_i,
    input  logic [rv_pkg::XLEN-1:0] op_b_i,
    input  rv_pkg::alu_op_e         alu_op_i,
    output logic [rv_pkg::XLEN-1:0] alu_result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = op_b_i[4:0]; // rv32i only looks at the low five bits
    assign lt_signed   = $signed(op_a_i) < $signed(op_b_i);
    assign lt_unsigned = op_a_i < op_b_i;

    // ---------------------------------------------------------------------
    // operation select
    // ---------------------------------------------------------------------

    always_comb begin
        case (alu_op_i)
            rv_pkg::ADD: begin
                alu_result_o = op_a_i + op_b_i;
            end
            rv_pkg::SUB: begin
                alu_result_o = op_a_i - op_b_i;
            end
            rv_pkg::SLL: begin
                alu_result_o = op_a_i << shamt;
            end
            rv_pkg::SLT: begin
                alu_result_o = {{(rv_pkg::XLEN-1){1'b0}}, lt_signed};
            end
            rv_pkg::SLTU: begin
                alu_result_o = {{(rv_pkg::XLEN-1){1'b0}}, lt_unsigned};
            end
            rv_pkg::XOR: begin
                alu_result_o = op_a_i ^ op_b_i;
            end
            rv_pkg::SRL: begin
                alu_result_o = op_a_i >> shamt;
            end
            rv_pkg::SRA: begin
                // arithmetic shift keeps the sign bit
                alu_result_o = $unsigned($signed(op_a_i) >>> shamt);
            end
            rv_pkg::OR: begin
                alu_result_o = op_a_i | op_b_i;
            end
            rv_pkg::AND: begin
                alu_result_o = op_a_i & op_b_i;
            end
            default: begin
                alu_result_o = '0; // unused funct7/funct3 pairs
            end
        endcase
    end

endmodule

/* verilog/rv_branch_unit.sv */
`timescale 1ns/1ps

module rv_branch_unit (
    input  logic [rv_pkg::XLEN-1:0] pc_i,
    input  rv_pkg::mopcode_e        opcode_i,
    input  logic [2:0]              funct3_i,
    input  logic [rv_pkg::XLEN-1:0] rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0] rs2_data_i,
    input  logic [rv_pkg::XLEN-1:0] imm_i,
    output logic [rv_pkg::XLEN-1:0] next_pc_o,
    output logic [rv_pkg::XLEN-1:0] link_addr_o
);

    logic                    equal;
    logic                    less_signed;
    logic                    less_unsigned;
    logic                    taken;
    logic [rv_pkg::XLEN-1:0] seq_pc;
    logic [rv_pkg::XLEN-1:0] pc_target;
    logic [rv_pkg::XLEN-1:0] reg_target;

    // own comparators, no alu flags involved
    assign equal         = rs1_data_i == rs2_data_i;
    assign less_signed   = $signed(rs1_data_i) < $signed(rs2_data_i);
    assign less_unsigned = rs1_data_i < rs2_data_i;

    always_comb begin
        case (rv_pkg::branch_cond_e'(funct3_i))
            rv_pkg::BEQ:  taken = equal;
            rv_pkg::BNE:  taken = !equal;
            rv_pkg::BLT:  taken = less_signed;
            rv_pkg::BGE:  taken = !less_signed;
            rv_pkg::BLTU: taken = less_unsigned;
            rv_pkg::BGEU: taken = !less_unsigned;
            default:      taken = 1'b0; // reserved funct3 falls through
        endcase
    end

    // ---------------------------------------------------------------------
    // target select
    // ---------------------------------------------------------------------

    assign seq_pc     = pc_i + rv_pkg::INSTR_STEP;
    assign pc_target  = pc_i + imm_i;
    assign reg_target = (rs1_data_i + imm_i) & ~{{(rv_pkg::XLEN-1){1'b0}}, 1'b1};

    always_comb begin
        case (opcode_i)
            rv_pkg::BRANCH: next_pc_o = taken ? pc_target : seq_pc;
            rv_pkg::JAL:    next_pc_o = pc_target;
            rv_pkg::JALR:   next_pc_o = reg_target; // bit 0 cleared
            default:        next_pc_o = seq_pc;
        endcase
    end

    assign link_addr_o = seq_pc; // return address for jal/jalr

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic                          clk,
    input  logic                          rst_n,
    // instruction fetch, four-phase req/ack
    output logic                          fetch_req_o,
    output logic [rv_pkg::XLEN-1:0]       fetch_addr_o,
    input  logic                          fetch_ack_i,
    input  logic [rv_pkg::XLEN-1:0]       fetch_data_i,
    // commit trace
    output logic                          wb_valid_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [rv_pkg::XLEN-1:0]       wb_data_o
);

    rv_pkg::core_state_e state_q;
    rv_pkg::core_state_e state_d;
    logic                req_q;
    logic                fetch_done;

    logic [rv_pkg::XLEN-1:0] pc_q;
    logic [rv_pkg::XLEN-1:0] instr_q;

    rv_pkg::mopcode_e              opcode;
    rv_pkg::alu_op_e               alu_op;
    logic [rv_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2;
    logic [2:0]                    funct3;
    logic                          funct7_b5;

    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic [rv_pkg::XLEN-1:0] imm_b;
    logic [rv_pkg::XLEN-1:0] imm_j;
    logic [rv_pkg::XLEN-1:0] imm;

    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;
    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_result;
    logic [rv_pkg::XLEN-1:0] next_pc;
    logic [rv_pkg::XLEN-1:0] link_addr;
    logic [rv_pkg::XLEN-1:0] wb_data;
    logic                    writes_rd;
    logic                    is_jump;
    logic                    rd_we;

    // ---------------------------------------------------------------------
    // fetch sequencer
    // ---------------------------------------------------------------------

    assign fetch_done = fetch_req_o && fetch_ack_i;

    always_comb begin
        case (state_q)
            rv_pkg::FETCH,
            rv_pkg::ACK_WAIT:    state_d = fetch_done ? rv_pkg::ACK_RELEASE : rv_pkg::ACK_WAIT;
            rv_pkg::ACK_RELEASE: state_d = fetch_ack_i ? rv_pkg::ACK_RELEASE : rv_pkg::EXECUTE;
            default:             state_d = rv_pkg::FETCH; // EXECUTE lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= rv_pkg::FETCH;
            req_q   <= 1'b0;
            pc_q    <= rv_pkg::RESET_PC;
        end else begin
            state_q <= state_d;
            // req high in every cycle that waits for ack
            req_q   <= (state_d == rv_pkg::FETCH) || (state_d == rv_pkg::ACK_WAIT);
            if (state_q == rv_pkg::EXECUTE) begin
                pc_q <= next_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr_q <= fetch_data_i;
        end
    end

    assign fetch_req_o  = req_q;
    assign fetch_addr_o = pc_q; // only moves in EXECUTE, so stable under req

    // ---------------------------------------------------------------------
    // decode
    // ---------------------------------------------------------------------

    assign opcode    = rv_pkg::mopcode_e'(instr_q[6:2]);
    assign rd        = instr_q[11:7];
    assign funct3    = instr_q[14:12];
    assign rs1       = instr_q[19:15];
    assign rs2       = instr_q[24:20];
    assign funct7_b5 = instr_q[30];

    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_u = {instr_q[31:12], 12'b0};
    assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                    instr_q[11:8], 1'b0};
    assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                    instr_q[30:21], 1'b0};

    always_comb begin
        imm       = '0;
        alu_op    = rv_pkg::ADD;
        writes_rd = 1'b0;
        is_jump   = 1'b0;
        case (opcode)
            rv_pkg::OP_IMM: begin
                imm       = imm_i;
                writes_rd = 1'b1;
                // only srai uses bit 30, addi has no sub form
                if (funct3 == 3'b101) begin
                    alu_op = rv_pkg::alu_op_e'({funct7_b5, funct3});
                end else begin
                    alu_op = rv_pkg::alu_op_e'({1'b0, funct3});
                end
            end
            rv_pkg::OP: begin
                alu_op    = rv_pkg::alu_op_e'({funct7_b5, funct3});
                writes_rd = 1'b1;
            end
            rv_pkg::LUI,
            rv_pkg::AUIPC: begin
                imm       = imm_u;
                writes_rd = 1'b1;
            end
            rv_pkg::BRANCH: imm = imm_b;
            rv_pkg::JAL: begin
                imm       = imm_j;
                writes_rd = 1'b1;
                is_jump   = 1'b1;
            end
            rv_pkg::JALR: begin
                imm       = imm_i;
                writes_rd = 1'b1;
                is_jump   = 1'b1;
            end
            default: ; // no-op, pc + 4 only
        endcase
    end

    // lui adds to zero, auipc to pc
    assign op_a = (opcode == rv_pkg::LUI)   ? '0 :
                  (opcode == rv_pkg::AUIPC) ? pc_q : rs1_data;
    assign op_b = (opcode == rv_pkg::OP) ? rs2_data : imm;

    // ---------------------------------------------------------------------
    // datapath
    // ---------------------------------------------------------------------

    rv_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1),
        .rs2_addr_i (rs2),
        .rd_addr_i  (rd),
        .rd_we_i    (rd_we),
        .rd_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_alu u_alu (
        .op_a_i       (op_a),
        .op_b_i       (op_b),
        .alu_op_i     (alu_op),
        .alu_result_o (alu_result)
    );

    rv_branch_unit u_branch_unit (
        .pc_i        (pc_q),
        .opcode_i    (opcode),
        .funct3_i    (funct3),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .imm_i       (imm),
        .next_pc_o   (next_pc),
        .link_addr_o (link_addr)
    );

    // write back, all in the EXECUTE cycle
    assign wb_data = is_jump ? link_addr : alu_result;
    assign rd_we   = (state_q == rv_pkg::EXECUTE) && writes_rd;

    assign wb_valid_o = rd_we && (rd != '0); // x0 writes leave no trace
    assign wb_rd_o    = rd;
    assign wb_data_o  = wb_data;

endmodule

/* verif/rv_core_checker.sv */
`timescale 1ns/1ps

module rv_core_checker (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          fetch_req_i,
    input logic [rv_pkg::XLEN-1:0]       fetch_addr_i,
    input logic                          fetch_ack_i,
    input logic                          wb_valid_i,
    input logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_i
);

    // ----------------------------------------------------------------------
    // fetch handshake
    // ----------------------------------------------------------------------

    req_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req_i && !fetch_ack_i |=> fetch_req_i)
        else $error("fetch_req_o fell before fetch_ack_i");

    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req_i |=> !fetch_req_i || $stable(fetch_addr_i))
        else $error("fetch_addr_o changed while fetch_req_o was high");

    // previous ack must be gone first
    no_req_under_ack: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_ack_i && !fetch_req_i |=> !fetch_req_i)
        else $error("fetch_req_o rose while fetch_ack_i was still high");

    // single-cycle commit pulse that never names x0
    commit_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid_i |-> (wb_rd_i != '0) ##1 !wb_valid_i)
        else $error("wb_valid_o raised for x0 or held longer than one cycle");

endmodule

bind rv_core rv_core_checker u_rv_core_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_req_i  (fetch_req_o),
    .fetch_addr_i (fetch_addr_o),
    .fetch_ack_i  (fetch_ack_i),
    .wb_valid_i   (wb_valid_o),
    .wb_rd_i      (wb_rd_o)
);

/* verif/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 2;  // input skew after the rising edge
    localparam int TIMEOUT_CYC = 40;
    localparam int SEED        = 64;
    localparam int MAX_ACK_DLY = 3;

    // seven-bit major opcodes
    localparam logic [6:0] OPC_IMM   = 7'h13;
    localparam logic [6:0] OPC_REG   = 7'h33;
    localparam logic [6:0] OPC_LUI   = 7'h37;
    localparam logic [6:0] OPC_AUIPC = 7'h17;
    localparam logic [6:0] OPC_JALR  = 7'h67;
    localparam logic [6:0] OPC_LOAD  = 7'h03; // runs as a no-op

    logic                          clk;
    logic                          rst_n;
    logic                          fetch_req;
    logic [rv_pkg::XLEN-1:0]       fetch_addr;
    logic                          fetch_ack;
    logic [rv_pkg::XLEN-1:0]       fetch_data;
    logic                          wb_valid;
    logic [rv_pkg::REG_ADDR_W-1:0] wb_rd;
    logic [rv_pkg::XLEN-1:0]       wb_data;

    logic timed_out;
    int   pass_count;
    int   fail_count;

    // stimulus table
    string       t_name[$];
    logic [31:0] t_pc[$];
    logic [31:0] t_instr[$];
    logic        t_we[$];
    logic [4:0]  t_rd[$];
    logic [31:0] t_data[$];
    logic [31:0] t_next[$];

    rv_core u_rv_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_req_o  (fetch_req),
        .fetch_addr_o (fetch_addr),
        .fetch_ack_i  (fetch_ack),
        .fetch_data_i (fetch_data),
        .wb_valid_o   (wb_valid),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // instruction encoders
    // ----------------------------------------------------------------------

    function automatic logic [31:0] r_type(input int f7, input int rd, input int f3,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input int rd, input int f3,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] op, input int rd, input int imm);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic add_test(input string name, input int pc, input logic [31:0] instr,
                            input logic we, input int rd, input logic [31:0] data,
                            input int next);
        t_name.push_back(name);
        t_pc.push_back(pc);
        t_instr.push_back(instr);
        t_we.push_back(we);
        t_rd.push_back(rd[4:0]);
        t_data.push_back(data);
        t_next.push_back(next);
    endtask

    function automatic int find_entry(input logic [31:0] addr);
        for (int k = 0; k < t_pc.size(); k++) begin
            if (t_pc[k] == addr) begin
                return k;
            end
        end
        return -1;
    endfunction

    // ----------------------------------------------------------------------
    // bus handling
    // ----------------------------------------------------------------------

    task automatic tick();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic wait_req();
        int n;
        n = 0;
        while (!fetch_req && !timed_out) begin
            tick();
            n++;
            if (!fetch_req && n >= TIMEOUT_CYC) begin
                $display("timeout: fetch_req_o never rose for the first fetch");
                timed_out = 1'b1;
            end
        end
    endtask

    // memory side of the four-phase handshake
    task automatic serve_fetch(input logic [31:0] instr);
        int delay;
        int n;
        delay = $urandom % (MAX_ACK_DLY + 1);
        n     = 0;
        repeat (delay) tick();
        fetch_ack  = 1'b1;
        fetch_data = instr;
        while (fetch_req && !timed_out) begin
            tick();
            n++;
            if (fetch_req && n >= TIMEOUT_CYC) begin
                $display("timeout: fetch_req_o never dropped after fetch_ack_i was raised");
                timed_out = 1'b1;
            end
        end
        repeat (delay) tick(); // slow ack release keeps the core in ACK_RELEASE
        fetch_ack = 1'b0;
    endtask

    task automatic await_outcome(output logic seen_we, output logic [4:0] seen_rd,
                                 output logic [31:0] seen_data);
        int n;
        seen_we   = 1'b0;
        seen_rd   = '0;
        seen_data = '0;
        n         = 0;
        while (!fetch_req && !timed_out) begin
            tick();
            n++;
            if (wb_valid) begin
                seen_we   = 1'b1;
                seen_rd   = wb_rd;
                seen_data = wb_data;
            end
            if (!fetch_req && n >= TIMEOUT_CYC) begin
                $display("timeout: neither a commit nor the next fetch request arrived");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic run_test(input int i);
        logic        seen_we;
        logic [4:0]  seen_rd;
        logic [31:0] seen_data;
        int          slot;
        int          errs;
        errs = 0;
        if (fetch_addr != t_pc[i]) begin
            $display("error: %0s fetch address expected %08h actual %08h",
                     t_name[i], t_pc[i], fetch_addr);
            errs++;
        end
        slot = find_entry(fetch_addr);
        if (slot < 0) begin
            $display("%0s: nothing in the table at address %08h", t_name[i], fetch_addr);
            errs++;
            serve_fetch(32'h0000_0013); // plain nop
        end else begin
            serve_fetch(t_instr[slot]);
        end
        await_outcome(seen_we, seen_rd, seen_data);
        if (timed_out) begin
            errs++;
        end else begin
            if (seen_we != t_we[i]) begin
                $display("error: %0s commit flag expected %0d actual %0d",
                         t_name[i], t_we[i], seen_we);
                errs++;
            end
            if (t_we[i] && seen_we && seen_rd != t_rd[i]) begin
                $display("error: %0s rd expected %0d actual %0d", t_name[i], t_rd[i], seen_rd);
                errs++;
            end
            if (t_we[i] && seen_we && seen_data != t_data[i]) begin
                $display("error: %0s data expected %08h actual %08h",
                         t_name[i], t_data[i], seen_data);
                errs++;
            end
            if (fetch_addr != t_next[i]) begin
                $display("error: %0s next fetch expected %08h actual %08h",
                         t_name[i], t_next[i], fetch_addr);
                errs++;
            end
        end
        if (errs == 0) begin
            $display("test %0s ok", t_name[i]);
            pass_count++;
        end else begin
            $display("test %0s failed", t_name[i]);
            fail_count++;
        end
    endtask

    // ----------------------------------------------------------------------
    // test program
    // ----------------------------------------------------------------------

    task automatic build_table();
        // x1 = 5 and x2 = -3 feed most later tests
        add_test("addi_pos", rv_pkg::RESET_PC, i_type(OPC_IMM, 1, 0, 0, 5), 1, 1, 32'h5, 'h04);
        add_test("addi_neg", 'h04, i_type(OPC_IMM, 2, 0, 0, -3), 1, 2, 32'hffff_fffd, 'h08);
        add_test("xori", 'h08, i_type(OPC_IMM, 3, 4, 1, 'h0f), 1, 3, 32'h0000_000a, 'h0c);
        add_test("ori", 'h0c, i_type(OPC_IMM, 4, 6, 1, 'h30), 1, 4, 32'h0000_0035, 'h10);
        add_test("andi", 'h10, i_type(OPC_IMM, 5, 7, 2, 'hff), 1, 5, 32'h0000_00fd, 'h14);
        add_test("slli", 'h14, i_type(OPC_IMM, 6, 1, 1, 'h004), 1, 6, 32'h0000_0050, 'h18);
        add_test("srli", 'h18, i_type(OPC_IMM, 7, 5, 2, 'h004), 1, 7, 32'h0fff_ffff, 'h1c);
        add_test("srai", 'h1c, i_type(OPC_IMM, 8, 5, 2, 'h401), 1, 8, 32'hffff_fffe, 'h20);
        add_test("add", 'h20, r_type('h00, 9, 0, 1, 2), 1, 9, 32'h0000_0002, 'h24);
        add_test("sub_neg", 'h24, r_type('h20, 10, 0, 2, 1), 1, 10, 32'hffff_fff8, 'h28);
        add_test("slt", 'h28, r_type('h00, 11, 2, 2, 1), 1, 11, 32'h0000_0001, 'h2c);
        add_test("sltu", 'h2c, r_type('h00, 12, 3, 2, 1), 1, 12, 32'h0000_0000, 'h30);
        add_test("sll", 'h30, r_type('h00, 13, 1, 1, 1), 1, 13, 32'h0000_00a0, 'h34);
        add_test("sra", 'h34, r_type('h20, 14, 5, 2, 1), 1, 14, 32'hffff_ffff, 'h38);
        add_test("and", 'h38, r_type('h00, 15, 7, 4, 5), 1, 15, 32'h0000_0035, 'h3c);
        add_test("or", 'h3c, r_type('h00, 16, 6, 3, 6), 1, 16, 32'h0000_005a, 'h40);
        add_test("lui", 'h40, u_type(OPC_LUI, 17, 'h12345), 1, 17, 32'h1234_5000, 'h44);
        add_test("auipc", 'h44, u_type(OPC_AUIPC, 18, 'h00001), 1, 18, 32'h0000_1044, 'h48);
        // branches commit nothing
        add_test("beq_taken", 'h48, b_type(0, 1, 1, 8), 0, 0, 32'h0, 'h50);
        add_test("beq_not", 'h50, b_type(0, 1, 2, 8), 0, 0, 32'h0, 'h54);
        add_test("bne_taken", 'h54, b_type(1, 1, 2, 12), 0, 0, 32'h0, 'h60);
        add_test("bne_not", 'h60, b_type(1, 1, 1, 8), 0, 0, 32'h0, 'h64);
        add_test("blt_taken", 'h64, b_type(4, 2, 1, 8), 0, 0, 32'h0, 'h6c);
        add_test("blt_not", 'h6c, b_type(4, 1, 2, 8), 0, 0, 32'h0, 'h70);
        add_test("bge_taken", 'h70, b_type(5, 1, 2, 8), 0, 0, 32'h0, 'h78);
        add_test("bge_not", 'h78, b_type(5, 2, 1, 8), 0, 0, 32'h0, 'h7c);
        add_test("bltu_taken", 'h7c, b_type(6, 1, 2, 8), 0, 0, 32'h0, 'h84);
        add_test("bltu_not", 'h84, b_type(6, 2, 1, 8), 0, 0, 32'h0, 'h88);
        add_test("bgeu_taken", 'h88, b_type(7, 2, 1, 8), 0, 0, 32'h0, 'h90);
        add_test("bgeu_not", 'h90, b_type(7, 1, 2, 8), 0, 0, 32'h0, 'h94);
        add_test("jal", 'h94, j_type(19, 12), 1, 19, 32'h0000_0098, 'ha0);
        add_test("jalr_base", 'ha0, i_type(OPC_IMM, 21, 0, 0, 'hb1), 1, 21, 32'h0000_00b1, 'ha4);
        add_test("jalr", 'ha4, i_type(OPC_JALR, 22, 0, 21, 4), 1, 22, 32'h0000_00a8, 'hb4);
        add_test("x0_write", 'hb4, i_type(OPC_IMM, 0, 0, 1, 7), 0, 0, 32'h0, 'hb8);
        add_test("x0_read", 'hb8, r_type('h00, 23, 0, 0, 1), 1, 23, 32'h0000_0005, 'hbc);
        add_test("load_nop", 'hbc, i_type(OPC_LOAD, 24, 2, 1, 0), 0, 0, 32'h0, 'hc0);
        add_test("after_nop", 'hc0, i_type(OPC_IMM, 25, 0, 24, 1), 1, 25, 32'h0000_0001, 'hc4);
    endtask

    initial begin
        fetch_ack  = 1'b0;
        fetch_data = '0;
        rst_n      = 1'b0;
        timed_out  = 1'b0;
        pass_count = 0;
        fail_count = 0;
        void'($urandom(SEED));
        build_table();

        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        wait_req();

        for (int i = 0; i < t_name.size() && !timed_out; i++) begin
            run_test(i);
        end

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* rv_core.f */
verilog/rv_pkg.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_branch_unit.sv
verilog/rv_core.sv
verif/rv_core_checker.sv
verif/rv_core_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = rv_core_tb
FILELIST = rv_core.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
